// File: hdl/proc_macros.svh
// ------------------------------------------------------------
// Widths and depths for the 16-bit pipeline and its memories
// PROC_MEM_ABITS must index both memory depths
// ------------------------------------------------------------
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

`define PROC_WORD       16
`define PROC_REG_BITS   3
`define PROC_IMEM_DEPTH 256
`define PROC_DMEM_DEPTH 256
`define PROC_MEM_ABITS  8

`endif

// File: hdl/procPkg.sv
// ------------------------------------------------------------
// Opcode and ALU encodings plus the pipeline register layouts
// Opcodes outside opcodeE are illegal and flagged in decode
// ------------------------------------------------------------
`default_nettype none
`include "proc_macros.svh"

package procPkg;

	typedef enum logic [4:0] {
		opNop  = 5'd0,
		opHalt = 5'd1,
		opAdd  = 5'd2,
		opSub  = 5'd3,
		opAnd  = 5'd4,
		opXor  = 5'd5,
		opAddi = 5'd6,
		opLd   = 5'd7,
		opSt   = 5'd8,
		opBeqz = 5'd9,
		opJ    = 5'd10
	} opcodeE;

	typedef enum logic [1:0] {
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluAnd = 2'd2,
		aluXor = 2'd3
	} aluOpE;

	typedef struct packed {
		logic                  valid;
		logic [`PROC_WORD-1:0] instr;
		logic [`PROC_WORD-1:0] pcPlusTwo;
	} ifIdT;

	typedef struct packed {
		logic                      valid;
		aluOpE                     aluOp;
		logic                      useImm;
		logic [`PROC_WORD-1:0]     opA;
		logic [`PROC_WORD-1:0]     opB;
		logic [`PROC_WORD-1:0]     imm;
		logic [`PROC_REG_BITS-1:0] destReg;
		logic                      regWrite;
		logic                      memRead;
		logic                      memWrite;
		logic                      halt;
	} idExT;

	typedef struct packed {
		logic                      valid;
		logic [`PROC_WORD-1:0]     result;
		logic [`PROC_WORD-1:0]     storeData;
		logic [`PROC_REG_BITS-1:0] destReg;
		logic                      regWrite;
		logic                      memRead;
		logic                      memWrite;
		logic                      halt;
	} exMemT;

	typedef struct packed {
		logic                      valid;
		logic [`PROC_WORD-1:0]     wbData;
		logic [`PROC_REG_BITS-1:0] destReg;
		logic                      regWrite;
		logic                      halt;
	} memWbT;

endpackage

`default_nettype wire

// File: hdl/fetchStage.sv
// ------------------------------------------------------------
// Instruction memory is loaded only while rstN is low
// Halted stays set until reset, PC is frozen from then on
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "proc_macros.svh"

module fetchStage (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       progWrEn,
	input  logic [`PROC_MEM_ABITS-1:0] progAddr,
	input  logic [`PROC_WORD-1:0]      progData,
	input  logic                       stall,
	input  logic                       redirect,
	input  logic [`PROC_WORD-1:0]      redirectTarget,
	input  procPkg::memWbT             memWb,
	output procPkg::ifIdT              ifId,
	output logic                       halted
);
	logic [`PROC_WORD-1:0] imem [`PROC_IMEM_DEPTH];
	logic [`PROC_WORD-1:0] pc;
	logic                  haltNow;

	// HALT reaching write-back freezes fetch in the same cycle
	assign haltNow = halted || (memWb.valid && memWb.halt);

	always_ff @(posedge clk) begin
		if (progWrEn)
			imem[progAddr] <= progData;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc     <= '0;
			ifId   <= '0;
			halted <= 1'b0;
		end else begin
			halted <= haltNow;
			if (haltNow) begin
				ifId.valid <= 1'b0;
			end else if (redirect) begin
				// Flush the wrong-path slot
				pc   <= redirectTarget;
				ifId <= '0;
			end else if (!stall) begin
				pc             <= pc + `PROC_WORD'd2;
				ifId.valid     <= 1'b1;
				ifId.instr     <= imem[pc[`PROC_MEM_ABITS:1]];
				ifId.pcPlusTwo <= pc + `PROC_WORD'd2;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
// ------------------------------------------------------------
// Register file write-through makes a WB result visible here
// Instructions after a HALT are dropped, err is sticky
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "proc_macros.svh"

module decodeStage (
	input  logic                      clk,
	input  logic                      rstN,
	input  procPkg::ifIdT             ifId,
	input  logic                      stall,
	input  procPkg::memWbT            memWb,
	input  logic [`PROC_REG_BITS-1:0] dbgRegAddr,
	output procPkg::idExT             idEx,
	output logic                      redirect,
	output logic [`PROC_WORD-1:0]     redirectTarget,
	output logic [`PROC_WORD-1:0]     dbgRegData,
	output logic                      err
);
	import procPkg::*;

	logic [`PROC_WORD-1:0]     regs [1 << `PROC_REG_BITS];
	opcodeE                    op;
	logic [`PROC_REG_BITS-1:0] rs, rt, rd;
	logic [`PROC_WORD-1:0]     rsVal, rtVal;
	logic [`PROC_WORD-1:0]     brOff, jOff;
	logic                      wbEn, inValid, haltSeen, illegal, brTaken;
	idExT                      dec;

	assign op      = opcodeE'(ifId.instr[15:11]);
	assign rs      = ifId.instr[10:8];
	assign rt      = ifId.instr[7:5];
	assign rd      = ifId.instr[4:2];
	assign inValid = ifId.valid && !haltSeen;
	assign wbEn    = memWb.valid && memWb.regWrite;

	always_ff @(posedge clk) begin
		if (wbEn)
			regs[memWb.destReg] <= memWb.wbData;
	end

	assign rsVal      = (wbEn && memWb.destReg == rs) ? memWb.wbData : regs[rs];
	assign rtVal      = (wbEn && memWb.destReg == rt) ? memWb.wbData : regs[rt];
	assign dbgRegData = regs[dbgRegAddr];

	// Branch and jump resolve here, one bubble when taken
	assign brOff          = {{(`PROC_WORD-8){ifId.instr[7]}}, ifId.instr[7:0]};
	assign jOff           = {{(`PROC_WORD-11){ifId.instr[10]}}, ifId.instr[10:0]};
	assign brTaken        = (op == opBeqz) && (rsVal == '0);
	assign redirect       = inValid && !stall && (brTaken || op == opJ);
	assign redirectTarget = ifId.pcPlusTwo + ((op == opJ) ? jOff : brOff);

	always_comb begin
		dec         = '0;
		dec.valid   = inValid;
		dec.aluOp   = aluAdd;
		dec.opA     = rsVal;
		dec.opB     = rtVal;
		dec.imm     = {{(`PROC_WORD-5){ifId.instr[4]}}, ifId.instr[4:0]};
		dec.destReg = rd;
		illegal     = 1'b0;
		case (op)
			opNop, opBeqz, opJ: ;
			opHalt: dec.halt = 1'b1;
			opAdd: dec.regWrite = 1'b1;
			opSub: begin
				dec.aluOp    = aluSub;
				dec.regWrite = 1'b1;
			end
			opAnd: begin
				dec.aluOp    = aluAnd;
				dec.regWrite = 1'b1;
			end
			opXor: begin
				dec.aluOp    = aluXor;
				dec.regWrite = 1'b1;
			end
			opAddi, opLd: begin
				dec.useImm   = 1'b1;
				dec.destReg  = rt;
				dec.regWrite = 1'b1;
				dec.memRead  = (op == opLd);
			end
			opSt: begin
				dec.useImm   = 1'b1;
				dec.memWrite = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idEx     <= '0;
			haltSeen <= 1'b0;
			err      <= 1'b0;
		end else begin
			if (stall || !inValid)
				idEx <= '0;
			else
				idEx <= dec;
			haltSeen <= haltSeen || (inValid && !stall && op == opHalt);
			err      <= err || (inValid && illegal);
		end
	end

endmodule

`default_nettype wire

// File: hdl/hazardUnit.sv
// ------------------------------------------------------------
// No forwarding, so decode waits until producers leave MEM
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
	input  procPkg::ifIdT  ifId,
	input  procPkg::idExT  idEx,
	input  procPkg::exMemT exMem,
	output logic           stall
);
	import procPkg::*;

	logic readsRs, readsRt, exHit, memHit;

	// Source registers actually read by the instruction in decode
	always_comb begin
		readsRs = 1'b0;
		readsRt = 1'b0;
		case (opcodeE'(ifId.instr[15:11]))
			opAdd, opSub, opAnd, opXor, opSt: begin
				readsRs = 1'b1;
				readsRt = 1'b1;
			end
			opAddi, opLd, opBeqz: readsRs = 1'b1;
			default: ;
		endcase
	end

	assign exHit = idEx.valid && idEx.regWrite &&
		((readsRs && idEx.destReg == ifId.instr[10:8]) ||
		(readsRt && idEx.destReg == ifId.instr[7:5]));
	assign memHit = exMem.valid && exMem.regWrite &&
		((readsRs && exMem.destReg == ifId.instr[10:8]) ||
		(readsRt && exMem.destReg == ifId.instr[7:5]));
	assign stall = ifId.valid && (exHit || memHit);

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
// ------------------------------------------------------------
// ALU doubles as address adder for LD and ST
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "proc_macros.svh"

module executeStage (
	input  logic           clk,
	input  logic           rstN,
	input  procPkg::idExT  idEx,
	output procPkg::exMemT exMem
);
	import procPkg::*;

	logic [`PROC_WORD-1:0] srcB, aluOut;

	assign srcB = idEx.useImm ? idEx.imm : idEx.opB;

	always_comb begin
		case (idEx.aluOp)
			aluAdd: aluOut = idEx.opA + srcB;
			aluSub: aluOut = idEx.opA - srcB;
			aluAnd: aluOut = idEx.opA & srcB;
			default: aluOut = idEx.opA ^ srcB;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem.valid     <= idEx.valid;
			exMem.result    <= aluOut;
			// rt value rides along for ST
			exMem.storeData <= idEx.opB;
			exMem.destReg   <= idEx.destReg;
			exMem.regWrite  <= idEx.regWrite;
			exMem.memRead   <= idEx.memRead;
			exMem.memWrite  <= idEx.memWrite;
			exMem.halt      <= idEx.halt;
		end
	end

endmodule

`default_nettype wire

// File: hdl/memoryStage.sv
// ------------------------------------------------------------
// Data memory is word indexed by the low address bits
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "proc_macros.svh"

module memoryStage (
	input  logic           clk,
	input  logic           rstN,
	input  procPkg::exMemT exMem,
	output procPkg::memWbT memWb
);
	logic [`PROC_WORD-1:0]      dmem [`PROC_DMEM_DEPTH];
	logic [`PROC_MEM_ABITS-1:0] addr;

	assign addr = exMem.result[`PROC_MEM_ABITS-1:0];

	always_ff @(posedge clk) begin
		if (exMem.valid && exMem.memWrite)
			dmem[addr] <= exMem.storeData;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWb <= '0;
		end else begin
			memWb.valid    <= exMem.valid;
			memWb.wbData   <= (exMem.valid && exMem.memRead) ? dmem[addr] : exMem.result;
			memWb.destReg  <= exMem.destReg;
			memWb.regWrite <= exMem.regWrite;
			memWb.halt     <= exMem.halt;
		end
	end

endmodule

`default_nettype wire

// File: hdl/proc.sv
// ------------------------------------------------------------
// Five-stage pipeline, branches resolved in decode, no bypass
// Load the program through the prog port while rstN is low
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "proc_macros.svh"

module proc (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       progWrEn,
	input  logic [`PROC_MEM_ABITS-1:0] progAddr,
	input  logic [`PROC_WORD-1:0]      progData,
	input  logic [`PROC_REG_BITS-1:0]  dbgRegAddr,
	output logic [`PROC_WORD-1:0]      dbgRegData,
	output logic                       halted,
	output logic                       err
);
	import procPkg::*;

	ifIdT                  ifId;
	idExT                  idEx;
	exMemT                 exMem;
	memWbT                 memWb;
	logic                  stall;
	logic                  redirect;
	logic [`PROC_WORD-1:0] redirectTarget;

	fetchStage fetch (
		.clk(clk),
		.rstN(rstN),
		.progWrEn(progWrEn),
		.progAddr(progAddr),
		.progData(progData),
		.stall(stall),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.memWb(memWb),
		.ifId(ifId),
		.halted(halted)
	);

	decodeStage decode (
		.clk(clk),
		.rstN(rstN),
		.ifId(ifId),
		.stall(stall),
		.memWb(memWb),
		.dbgRegAddr(dbgRegAddr),
		.idEx(idEx),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.dbgRegData(dbgRegData),
		.err(err)
	);

	hazardUnit hdu (
		.ifId(ifId),
		.idEx(idEx),
		.exMem(exMem),
		.stall(stall)
	);

	executeStage execute (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.exMem(exMem)
	);

	// Write-back mux lives in memory stage output, regfile in decode
	memoryStage memory (
		.clk(clk),
		.rstN(rstN),
		.exMem(exMem),
		.memWb(memWb)
	);

endmodule

`default_nettype wire

// File: testbench/procTb.sv
// ------------------------------------------------------------
// Directed tests for the pipeline with programs loaded under reset
// Registers are not reset, so each program clears what it reads
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module procTb;
	import procPkg::*;

	localparam int haltTimeout = 200;

	logic        clk;
	logic        rstN;
	logic        progWrEn;
	logic [7:0]  progAddr;
	logic [15:0] progData;
	logic [2:0]  dbgRegAddr;
	logic [15:0] dbgRegData;
	logic        halted;
	logic        err;

	logic [15:0] prog [$];
	logic [31:0] lcgState = 32'ha174;
	int          checks = 0;
	int          errors = 0;

	proc DUT (
		.clk(clk),
		.rstN(rstN),
		.progWrEn(progWrEn),
		.progAddr(progAddr),
		.progData(progData),
		.dbgRegAddr(dbgRegAddr),
		.dbgRegData(dbgRegData),
		.halted(halted),
		.err(err)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic logic [4:0] randImm5();
		logic [31:0] r;
		r = nextRand();
		return r[20:16];
	endfunction

	function automatic logic [15:0] sext5(logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	// Instruction encoders with the opcode in bits 15..11
	function automatic logic [15:0] rInstr(opcodeE op, int rs, int rt, int rd);
		return {op, 3'(rs), 3'(rt), 3'(rd), 2'b00};
	endfunction

	function automatic logic [15:0] iInstr(opcodeE op, int rs, int rt, logic [4:0] imm);
		return {op, 3'(rs), 3'(rt), imm};
	endfunction

	function automatic logic [15:0] beqzInstr(int rs, logic [7:0] off);
		return {opBeqz, 3'(rs), off};
	endfunction

	function automatic logic [15:0] jumpInstr(logic [10:0] off);
		return {opJ, off};
	endfunction

	function automatic logic [15:0] haltInstr();
		return {opHalt, 11'd0};
	endfunction

	task automatic checkValue(string testName, logic [15:0] expected, logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s expected=%h actual=%h", testName, expected, actual);
			errors++;
		end
	endtask

	// Reset stays low for the whole load plus two cycles
	task automatic loadProgram();
		int i;
		@(posedge clk);
		rstN <= 1'b0;
		for (i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			progWrEn <= 1'b1;
			progAddr <= 8'(i);
			progData <= prog[i];
		end
		@(posedge clk);
		progWrEn <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic releaseReset();
		@(posedge clk);
		rstN <= 1'b1;
	endtask

	task automatic waitHalted(string testName);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (halted !== 1'b1 && cycles < haltTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("ERROR %s: program did not halt within %0d cycles", testName, haltTimeout);
			errors++;
		end
	endtask

	task automatic runProgram(string testName);
		loadProgram();
		releaseReset();
		waitHalted(testName);
	endtask

	task automatic checkReg(string testName, int r, logic [15:0] expected);
		@(posedge clk);
		dbgRegAddr <= 3'(r);
		@(negedge clk);
		checkValue($sformatf("%s r%0d", testName, r), expected, dbgRegData);
	endtask

	task automatic resetStateTest();
		prog.delete();
		prog.push_back(rInstr(opXor, 0, 0, 0));
		prog.push_back(haltInstr());
		loadProgram();
		@(negedge clk);
		checkValue("reset halted during", 16'd0, {15'd0, halted});
		checkValue("reset err during", 16'd0, {15'd0, err});
		releaseReset();
		// First active edge after release
		@(posedge clk);
		@(negedge clk);
		checkValue("reset halted after", 16'd0, {15'd0, halted});
		checkValue("reset err after", 16'd0, {15'd0, err});
		waitHalted("reset");
	endtask

	// Stale reads in back-to-back dependencies show up as wrong values
	task automatic chainTest();
		logic [4:0]  a, b, c;
		logic [15:0] v1, v2, v3, v4, v5, v6, v7;
		a = randImm5();
		b = randImm5();
		c = randImm5();
		prog.delete();
		prog.push_back(rInstr(opXor, 0, 0, 0));
		prog.push_back(iInstr(opAddi, 0, 1, a));
		prog.push_back(iInstr(opAddi, 0, 2, b));
		prog.push_back(iInstr(opAddi, 0, 3, c));
		prog.push_back(rInstr(opAdd, 1, 2, 4));
		prog.push_back(rInstr(opSub, 4, 3, 5));
		prog.push_back(rInstr(opAnd, 5, 1, 6));
		prog.push_back(rInstr(opXor, 6, 4, 7));
		prog.push_back(haltInstr());
		runProgram("chain");
		v1 = sext5(a);
		v2 = sext5(b);
		v3 = sext5(c);
		v4 = v1 + v2;
		v5 = v4 - v3;
		v6 = v5 & v1;
		v7 = v6 ^ v4;
		checkReg("chain", 1, v1);
		checkReg("chain", 2, v2);
		checkReg("chain", 3, v3);
		checkReg("chain", 4, v4);
		checkReg("chain", 5, v5);
		checkReg("chain", 6, v6);
		checkReg("chain", 7, v7);
		checkValue("chain err", 16'd0, {15'd0, err});
	endtask

	task automatic loadStoreTest();
		logic [4:0]  a, b;
		logic [15:0] sum, diff;
		a = randImm5();
		b = randImm5();
		prog.delete();
		prog.push_back(rInstr(opXor, 0, 0, 0));
		prog.push_back(iInstr(opAddi, 0, 1, a));
		prog.push_back(iInstr(opAddi, 0, 2, b));
		prog.push_back(rInstr(opAdd, 1, 2, 3));
		prog.push_back(rInstr(opSub, 1, 2, 4));
		prog.push_back(iInstr(opSt, 0, 3, 5'd5));
		prog.push_back(iInstr(opSt, 0, 4, 5'd9));
		prog.push_back(iInstr(opLd, 0, 5, 5'd5));
		prog.push_back(iInstr(opLd, 0, 6, 5'd9));
		prog.push_back(rInstr(opAdd, 5, 6, 7));
		prog.push_back(haltInstr());
		runProgram("loadstore");
		sum  = sext5(a) + sext5(b);
		diff = sext5(a) - sext5(b);
		checkReg("loadstore", 5, sum);
		checkReg("loadstore", 6, diff);
		checkReg("loadstore", 7, sum + diff);
		checkValue("loadstore err", 16'd0, {15'd0, err});
	endtask

	// Offsets of 2 bytes skip exactly one instruction
	task automatic branchTest();
		prog.delete();
		prog.push_back(rInstr(opXor, 0, 0, 0));
		prog.push_back(rInstr(opXor, 2, 2, 2));
		prog.push_back(rInstr(opXor, 3, 3, 3));
		prog.push_back(rInstr(opXor, 4, 4, 4));
		prog.push_back(iInstr(opAddi, 0, 1, 5'd1));
		prog.push_back(beqzInstr(0, 8'd2));
		prog.push_back(iInstr(opAddi, 0, 2, 5'd7));
		prog.push_back(beqzInstr(1, 8'd2));
		prog.push_back(iInstr(opAddi, 0, 3, 5'd9));
		prog.push_back(jumpInstr(11'd2));
		prog.push_back(iInstr(opAddi, 0, 4, 5'd11));
		prog.push_back(iInstr(opAddi, 0, 5, 5'd13));
		prog.push_back(haltInstr());
		runProgram("branch");
		checkReg("branch taken", 2, 16'd0);
		checkReg("branch fallthrough", 3, 16'd9);
		checkReg("branch jump", 4, 16'd0);
		checkReg("branch target", 5, 16'd13);
		checkValue("branch err", 16'd0, {15'd0, err});
	endtask

	// Register fields of the illegal word point at r1 and r2
	task automatic illegalTest();
		logic [4:0] a, b;
		a = randImm5();
		b = randImm5();
		prog.delete();
		prog.push_back(rInstr(opXor, 0, 0, 0));
		prog.push_back(iInstr(opAddi, 0, 1, a));
		prog.push_back(iInstr(opAddi, 0, 2, b));
		prog.push_back({5'd31, 3'd1, 3'd2, 3'd1, 2'b00});
		prog.push_back(haltInstr());
		runProgram("illegal");
		checkValue("illegal err", 16'd1, {15'd0, err});
		checkReg("illegal", 1, sext5(a));
		checkReg("illegal", 2, sext5(b));
	endtask

	initial begin
		rstN       <= 1'b0;
		progWrEn   <= 1'b0;
		progAddr   <= '0;
		progData   <= '0;
		dbgRegAddr <= '0;
		resetStateTest();
		chainTest();
		loadStoreTest();
		branchTest();
		illegalTest();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+hdl
hdl/procPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/proc.sv
testbench/procTb.sv

// File: Makefile
SIM = obj_dir/procSim

.PHONY: compile run clean

compile:
	verilator --binary --timing -f files.f --top-module procTb -o procSim --Mdir obj_dir

run: compile
	./$(SIM) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
